//--- hw/wb_axi_pkg.sv
package wb_axi_pkg;

    localparam int unsigned LINE_BITS      = 512;
    localparam int unsigned WORD_BITS      = 32;
    localparam int unsigned BEATS_PER_LINE = LINE_BITS / WORD_BITS;

    localparam logic [3:0] CSR_ADDR_CTRL     = 4'h0;
    localparam logic [3:0] CSR_ADDR_DONE     = 4'h4;
    localparam logic [3:0] CSR_ADDR_ERR      = 4'h8;
    localparam logic [3:0] CSR_ADDR_ERR_ADDR = 4'hc;

    localparam logic [1:0] RESP_OKAY     = 2'b00;
    localparam logic [2:0] AXI_SIZE_WORD = 3'b010; // 4 bytes per beat

    typedef logic [31:0]          addr_t;
    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [3:0]           beat_idx_t;
    typedef logic [7:0]           axi_len_t;
    typedef logic [1:0]           axi_resp_t;
    typedef logic [31:0]          count_t;

    typedef struct packed {
        addr_t addr;
        logic  uncache;            // single word store instead of a full line
        line_t line;
    } wb_req_t;

    typedef struct packed {
        logic error;
    } wb_resp_t;

    typedef struct packed {
        addr_t    addr;
        axi_len_t len;
        logic [2:0] size;
    } axi_aw_t;

    typedef struct packed {
        word_t      data;
        logic [3:0] strb;
        logic       last;
    } axi_w_t;

    typedef struct packed {
        logic  error;
        addr_t addr;               // aligned address as it went out on AW
    } wb_event_t;

    typedef struct packed {
        logic       write;
        logic [3:0] offset;
        word_t      wdata;
    } csr_req_t;

    typedef enum logic [2:0] {IDLE, ADDR, DATA, RESP, DONE} wb_state_e;

endpackage

//--- hw/wb_write_engine.sv
`timescale 1ns/1ps

module wb_write_engine (
    input  logic                  clk,
    input  logic                  rstn,

    input  logic                  req_valid,
    output logic                  req_ready,
    input  wb_axi_pkg::wb_req_t   req,
    output logic                  resp_valid,
    input  logic                  resp_ready,
    output wb_axi_pkg::wb_resp_t  resp,

    input  logic                  enable,

    output logic                  awvalid,
    input  logic                  awready,
    output wb_axi_pkg::axi_aw_t   aw,
    output logic                  wvalid,
    input  logic                  wready,
    output wb_axi_pkg::axi_w_t    w,
    input  logic                  bvalid,
    output logic                  bready,
    input  wb_axi_pkg::axi_resp_t bresp,

    output logic                  evt_valid,
    output wb_axi_pkg::wb_event_t evt
);

    wb_axi_pkg::wb_state_e state;
    wb_axi_pkg::wb_state_e state_next;

    wb_axi_pkg::addr_t     addr_q;
    wb_axi_pkg::line_t     line_q;
    logic                  uncache_q;
    logic                  err_q;
    wb_axi_pkg::beat_idx_t beat_q;

    wb_axi_pkg::beat_idx_t word_sel;
    wb_axi_pkg::addr_t     aw_addr;
    logic                  last_beat;
    logic                  bresp_err;

    logic                  req_fire;
    logic                  aw_fire;
    logic                  w_fire;
    logic                  b_fire;
    logic                  resp_fire;

    assign req_ready  = (state == wb_axi_pkg::IDLE) && enable; // enable only gates new work
    assign awvalid    = (state == wb_axi_pkg::ADDR);
    assign wvalid     = (state == wb_axi_pkg::DATA);
    assign bready     = (state == wb_axi_pkg::RESP);
    assign resp_valid = (state == wb_axi_pkg::DONE);

    assign req_fire  = req_valid && req_ready;
    assign aw_fire   = awvalid && awready;
    assign w_fire    = wvalid && wready;
    assign b_fire    = bvalid && bready;
    assign resp_fire = resp_valid && resp_ready;

    assign bresp_err = (bresp != wb_axi_pkg::RESP_OKAY);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= wb_axi_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            wb_axi_pkg::IDLE: begin
                if (req_fire) begin
                    state_next = wb_axi_pkg::ADDR;
                end
            end
            wb_axi_pkg::ADDR: begin
                if (aw_fire) begin
                    state_next = wb_axi_pkg::DATA;
                end
            end
            wb_axi_pkg::DATA: begin
                if (w_fire && last_beat) begin
                    state_next = wb_axi_pkg::RESP;
                end
            end
            wb_axi_pkg::RESP: begin
                if (b_fire) begin
                    state_next = wb_axi_pkg::DONE;
                end
            end
            wb_axi_pkg::DONE: begin
                if (resp_fire) begin
                    state_next = wb_axi_pkg::IDLE;
                end
            end
            default: begin
                state_next = wb_axi_pkg::IDLE;
            end
        endcase
    end

    // request payload, held for the whole transaction
    always_ff @(posedge clk) begin
        if (req_fire) begin
            addr_q    <= req.addr;
            line_q    <= req.line;
            uncache_q <= req.uncache;
        end
    end

    always_ff @(posedge clk) begin
        if (b_fire) begin
            err_q <= bresp_err; // bresp is only valid during the handshake
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_q <= '0;
        end else if (state == wb_axi_pkg::IDLE) begin
            beat_q <= '0;
        end else if (w_fire) begin
            beat_q <= beat_q + 4'd1; // wraps back to 0 after beat 15
        end
    end

    // lines go out aligned to 64 bytes, uncached stores to the word
    always_comb begin
        if (uncache_q) begin
            aw_addr = {addr_q[31:2], 2'b00};
        end else begin
            aw_addr = {addr_q[31:6], 6'b00_0000};
        end
    end

    always_comb begin
        aw.addr = aw_addr;
        aw.size = wb_axi_pkg::AXI_SIZE_WORD;
        if (uncache_q) begin
            aw.len = '0;
        end else begin
            aw.len = wb_axi_pkg::axi_len_t'(wb_axi_pkg::BEATS_PER_LINE - 1);
        end
    end

    assign word_sel  = uncache_q ? addr_q[5:2] : beat_q; // store picks its word from the line
    assign last_beat = uncache_q ||
                       (beat_q == wb_axi_pkg::beat_idx_t'(wb_axi_pkg::BEATS_PER_LINE - 1));

    always_comb begin
        w.data = line_q[word_sel * wb_axi_pkg::WORD_BITS +: wb_axi_pkg::WORD_BITS];
        w.strb = '1;
        w.last = last_beat;
    end

    assign evt_valid  = b_fire;
    assign evt.error  = bresp_err;
    assign evt.addr   = aw_addr;

    assign resp.error = err_q;

endmodule

//--- hw/wb_ctrl_regs.sv
`timescale 1ns/1ps

module wb_ctrl_regs (
    input  logic                  clk,
    input  logic                  rstn,

    input  logic                  csr_valid,
    output logic                  csr_ready,
    input  wb_axi_pkg::csr_req_t  csr,
    output logic                  csr_rvalid,
    output wb_axi_pkg::word_t     csr_rdata,

    input  logic                  evt_valid,
    input  wb_axi_pkg::wb_event_t evt,

    output logic                  enable
);

    logic                 csr_wr;
    logic                 csr_rd;
    wb_axi_pkg::count_t   done_cnt;
    wb_axi_pkg::count_t   err_cnt;
    wb_axi_pkg::addr_t    err_addr;
    wb_axi_pkg::word_t    rdata_next;

    assign csr_ready = 1'b1;

    assign csr_wr = csr_valid && csr_ready && csr.write;
    assign csr_rd = csr_valid && csr_ready && !csr.write;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            enable <= 1'b1;
        end else if (csr_wr && (csr.offset == wb_axi_pkg::CSR_ADDR_CTRL)) begin
            enable <= csr.wdata[0];
        end
    end

    // a clear from software wins over an event landing in the same cycle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            done_cnt <= '0;
        end else if (csr_wr && (csr.offset == wb_axi_pkg::CSR_ADDR_DONE)) begin
            done_cnt <= '0;
        end else if (evt_valid) begin
            done_cnt <= done_cnt + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            err_cnt <= '0;
        end else if (csr_wr && (csr.offset == wb_axi_pkg::CSR_ADDR_ERR)) begin
            err_cnt <= '0;
        end else if (evt_valid && evt.error) begin
            err_cnt <= err_cnt + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            err_addr <= '0;
        end else if (evt_valid && evt.error) begin
            err_addr <= evt.addr; // keeps only the most recent failure
        end
    end

    always_comb begin
        unique case (csr.offset)
            wb_axi_pkg::CSR_ADDR_CTRL:     rdata_next = {31'd0, enable};
            wb_axi_pkg::CSR_ADDR_DONE:     rdata_next = done_cnt;
            wb_axi_pkg::CSR_ADDR_ERR:      rdata_next = err_cnt;
            wb_axi_pkg::CSR_ADDR_ERR_ADDR: rdata_next = err_addr;
            default:                       rdata_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            csr_rvalid <= 1'b0;
        end else begin
            csr_rvalid <= csr_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (csr_rd) begin
            csr_rdata <= rdata_next;
        end
    end

endmodule

//--- hw/wb_axi_writer.sv
`timescale 1ns/1ps

module wb_axi_writer (
    input  logic                  clk,
    input  logic                  rstn,

    input  logic                  req_valid,
    output logic                  req_ready,
    input  wb_axi_pkg::wb_req_t   req,
    output logic                  resp_valid,
    input  logic                  resp_ready,
    output wb_axi_pkg::wb_resp_t  resp,

    output logic                  awvalid,
    input  logic                  awready,
    output wb_axi_pkg::axi_aw_t   aw,
    output logic                  wvalid,
    input  logic                  wready,
    output wb_axi_pkg::axi_w_t    w,
    input  logic                  bvalid,
    output logic                  bready,
    input  wb_axi_pkg::axi_resp_t bresp,

    input  logic                  csr_valid,
    output logic                  csr_ready,
    input  wb_axi_pkg::csr_req_t  csr,
    output logic                  csr_rvalid,
    output wb_axi_pkg::word_t     csr_rdata
);

    logic                  enable;
    logic                  evt_valid;
    wb_axi_pkg::wb_event_t evt;

    wb_write_engine engine_inst (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp),
        .enable     (enable),
        .awvalid    (awvalid),
        .awready    (awready),
        .aw         (aw),
        .wvalid     (wvalid),
        .wready     (wready),
        .w          (w),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .evt_valid  (evt_valid),
        .evt        (evt)
    );

    wb_ctrl_regs regs_inst (
        .clk        (clk),
        .rstn       (rstn),
        .csr_valid  (csr_valid),
        .csr_ready  (csr_ready),
        .csr        (csr),
        .csr_rvalid (csr_rvalid),
        .csr_rdata  (csr_rdata),
        .evt_valid  (evt_valid),
        .evt        (evt),
        .enable     (enable)
    );

endmodule

//--- bench/wb_axi_writer_properties.sv
`timescale 1ns/1ps

module wb_axi_writer_properties (
    input logic                 clk,
    input logic                 rstn,
    input logic                 req_valid,
    input logic                 req_ready,
    input logic                 resp_valid,
    input logic                 resp_ready,
    input wb_axi_pkg::wb_resp_t resp,
    input logic                 awvalid,
    input logic                 awready,
    input wb_axi_pkg::axi_aw_t  aw,
    input logic                 wvalid,
    input logic                 wready,
    input wb_axi_pkg::axi_w_t   w,
    input logic                 bready
);

    // the reset values show up from the cycle after any reset cycle
    reset_state: assert property (@(posedge clk)
        !rstn |=> !awvalid && !wvalid && !bready && !resp_valid && req_ready)
        else $error("engine outputs are not idle after reset");

    aw_stable: assert property (@(posedge clk) disable iff (!rstn)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("AW channel changed while stalled");

    w_stable: assert property (@(posedge clk) disable iff (!rstn)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("W channel changed while stalled");

    resp_stable: assert property (@(posedge clk) disable iff (!rstn)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("completion changed before it was accepted");

    resp_once: assert property (@(posedge clk) disable iff (!rstn)
        resp_valid && resp_ready |=> !resp_valid)
        else $error("second completion for one request");

    aw_after_req: assert property (@(posedge clk) disable iff (!rstn)
        $rose(awvalid) |-> $past(req_valid && req_ready))
        else $error("write address without an accepted request");

    // bready opens only once the last beat has gone out
    b_after_last: assert property (@(posedge clk) disable iff (!rstn)
        $rose(bready) |-> $past(wvalid && wready && w.last))
        else $error("bready raised before the last data beat");

endmodule

//--- bench/tb_wb_axi_writer.sv
`timescale 1ns/1ps

module tb_wb_axi_writer;

    logic                  clk;
    logic                  rstn;
    logic                  req_valid;
    logic                  req_ready;
    wb_axi_pkg::wb_req_t   req;
    logic                  resp_valid;
    logic                  resp_ready;
    wb_axi_pkg::wb_resp_t  resp;
    logic                  awvalid;
    logic                  awready;
    wb_axi_pkg::axi_aw_t   aw;
    logic                  wvalid;
    logic                  wready;
    wb_axi_pkg::axi_w_t    w;
    logic                  bvalid;
    logic                  bready;
    wb_axi_pkg::axi_resp_t bresp;
    logic                  csr_valid;
    logic                  csr_ready;
    wb_axi_pkg::csr_req_t  csr;
    logic                  csr_rvalid;
    wb_axi_pkg::word_t     csr_rdata;

    wb_axi_pkg::axi_aw_t   aw_seen[$];
    wb_axi_pkg::axi_w_t    w_seen[$];
    logic                  b_err_q[$];
    int unsigned           b_count;
    int unsigned           n_writes;
    int unsigned           n_errors;
    wb_axi_pkg::addr_t     last_err_addr;

    wb_axi_writer wb_axi_writer_inst (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp),
        .awvalid    (awvalid),
        .awready    (awready),
        .aw         (aw),
        .wvalid     (wvalid),
        .wready     (wready),
        .w          (w),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .csr_valid  (csr_valid),
        .csr_ready  (csr_ready),
        .csr        (csr),
        .csr_rvalid (csr_rvalid),
        .csr_rdata  (csr_rdata)
    );

    bind wb_axi_writer wb_axi_writer_properties props_inst (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp),
        .awvalid    (awvalid),
        .awready    (awready),
        .aw         (aw),
        .wvalid     (wvalid),
        .wready     (wready),
        .w          (w),
        .bready     (bready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        string msg;
        assert (got === exp) else begin
            msg = $sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp);
            stop_with_failure(msg);
        end
    endtask

    // 40 requests at most, each allowed 200 cycles
    initial begin
        repeat (40 * 200) @(posedge clk);
        stop_with_failure("timeout, the DUT stopped making progress");
    end

    // slave ready lines stall at random
    initial begin
        awready = 1'b0;
        wready  = 1'b0;
        forever begin
            @(negedge clk);
            awready = $urandom % 4 != 0;
            wready  = $urandom % 4 != 0;
        end
    end

    always @(posedge clk) begin
        if (rstn && awvalid && awready) begin
            aw_seen.push_back(aw);
        end
        if (rstn && wvalid && wready) begin
            w_seen.push_back(w);
        end
    end

    // B channel answers after the last beat and fails every fourth write with SLVERR
    initial begin
        int unsigned stall;
        bvalid = 1'b0;
        bresp  = wb_axi_pkg::RESP_OKAY;
        forever begin
            @(posedge clk);
            if (rstn && wvalid && wready && w.last) begin
                stall = $urandom % 4;
                repeat (stall) @(negedge clk);
                @(negedge clk);
                bvalid = 1'b1;
                bresp  = (b_count % 4 == 3) ? 2'b10 : wb_axi_pkg::RESP_OKAY;
                b_err_q.push_back(b_count % 4 == 3);
                b_count++;
                do @(posedge clk); while (!bready);
                @(negedge clk);
                bvalid = 1'b0;
                bresp  = wb_axi_pkg::RESP_OKAY;
            end
        end
    end

    task automatic csr_write(input logic [3:0] offset, input wb_axi_pkg::word_t data);
        @(negedge clk);
        csr_valid  = 1'b1;
        csr.write  = 1'b1;
        csr.offset = offset;
        csr.wdata  = data;
        do @(posedge clk); while (!csr_ready);
        @(negedge clk);
        csr_valid = 1'b0;
        csr.write = 1'b0;
    endtask

    task automatic csr_read(input logic [3:0] offset, output wb_axi_pkg::word_t data);
        @(negedge clk);
        csr_valid  = 1'b1;
        csr.write  = 1'b0;
        csr.offset = offset;
        do @(posedge clk); while (!csr_ready);
        @(negedge clk);
        csr_valid = 1'b0;
        do @(posedge clk); while (!csr_rvalid); // read data comes a cycle after the handshake
        data = csr_rdata;
    endtask

    task automatic run_write(input wb_axi_pkg::addr_t addr, input logic uncache,
                             input wb_axi_pkg::line_t line);
        wb_axi_pkg::axi_aw_t got_aw;
        wb_axi_pkg::axi_w_t  got_w;
        wb_axi_pkg::addr_t   exp_addr;
        int                  beats;
        int                  sel;
        logic                got_err;
        logic                exp_err;
        @(negedge clk);
        req_valid   = 1'b1;
        req.addr    = addr;
        req.uncache = uncache;
        req.line    = line;
        do @(posedge clk); while (!req_ready);
        @(negedge clk);
        req_valid = 1'b0;
        do begin
            @(negedge clk);
            resp_ready = $urandom % 3 != 0;
            @(posedge clk);
        end while (!(resp_valid && resp_ready));
        got_err = resp.error;
        @(negedge clk);
        resp_ready = 1'b0;

        exp_addr = uncache ? {addr[31:2], 2'b00} : {addr[31:6], 6'b0};
        beats    = uncache ? 1 : 16;
        check_equal("aw handshakes", 32'(aw_seen.size()), 32'd1);
        got_aw = aw_seen.pop_front();
        check_equal("aw.addr", got_aw.addr, exp_addr);
        check_equal("aw.len", 32'(got_aw.len), 32'(beats - 1));
        check_equal("aw.size", 32'(got_aw.size), 32'd2);
        check_equal("w handshakes", 32'(w_seen.size()), 32'(beats));
        for (int k = 0; k < beats; k++) begin
            sel   = uncache ? int'(addr[5:2]) : k;
            got_w = w_seen.pop_front();
            check_equal("w.data", got_w.data, line[sel * 32 +: 32]);
            check_equal("w.strb", 32'(got_w.strb), 32'hf);
            check_equal("w.last", 32'(got_w.last), 32'(k == beats - 1));
        end
        check_equal("b handshakes", 32'(b_err_q.size()), 32'd1);
        exp_err = b_err_q.pop_front();
        check_equal("resp.error", 32'(got_err), 32'(exp_err));
        n_writes++;
        if (exp_err) begin
            n_errors++;
            last_err_addr = exp_addr;
        end
    endtask

    initial begin
        wb_axi_pkg::addr_t addr;
        wb_axi_pkg::line_t line;
        wb_axi_pkg::word_t rd;
        logic              uncache;
        void'($urandom(32'h2764));
        rstn          = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        resp_ready    = 1'b0;
        csr_valid     = 1'b0;
        csr           = '0;
        b_count       = 0;
        n_writes      = 0;
        n_errors      = 0;
        last_err_addr = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        // first a line, then a store, then a random mix
        for (int i = 0; i < 34; i++) begin
            uncache = (i == 1) || (i > 1 && $urandom % 3 == 0);
            addr    = $urandom;
            for (int k = 0; k < 16; k++) begin
                line[k * 32 +: 32] = $urandom;
            end
            run_write(addr, uncache, line);
        end

        csr_write(wb_axi_pkg::CSR_ADDR_CTRL, 32'd0);
        csr_read(wb_axi_pkg::CSR_ADDR_CTRL, rd);
        check_equal("ctrl", rd, 32'd0);
        addr = $urandom;
        for (int k = 0; k < 16; k++) begin
            line[k * 32 +: 32] = $urandom;
        end
        @(negedge clk);
        req_valid   = 1'b1;
        req.addr    = addr;
        req.uncache = 1'b0;
        req.line    = line;
        repeat (20) begin
            @(posedge clk);
            check_equal("req_ready", 32'(req_ready), 32'd0);
            check_equal("awvalid", 32'(awvalid), 32'd0);
        end
        @(negedge clk);
        req_valid = 1'b0;
        csr_write(wb_axi_pkg::CSR_ADDR_CTRL, 32'd1);
        run_write(addr, 1'b0, line); // the refused request goes through once enabled

        csr_read(wb_axi_pkg::CSR_ADDR_DONE, rd);
        check_equal("done count", rd, n_writes);
        csr_read(wb_axi_pkg::CSR_ADDR_ERR, rd);
        check_equal("error count", rd, n_errors);
        csr_read(wb_axi_pkg::CSR_ADDR_ERR_ADDR, rd);
        check_equal("last error addr", rd, last_err_addr);
        csr_write(wb_axi_pkg::CSR_ADDR_DONE, 32'd0);
        csr_read(wb_axi_pkg::CSR_ADDR_DONE, rd);
        check_equal("done count after clear", rd, 32'd0);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- verilog.f
hw/wb_axi_pkg.sv
hw/wb_write_engine.sv
hw/wb_ctrl_regs.sv
hw/wb_axi_writer.sv
bench/wb_axi_writer_properties.sv
bench/tb_wb_axi_writer.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it, the exit status is the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module tb_wb_axi_writer \
    -f verilog.f \
    -o sim_wb_axi_writer &&
./obj_dir/sim_wb_axi_writer ||
{
    echo "simulation did not complete cleanly"
    exit 1
}
